//--- Bender.yml
package:
  name: csr_unit

export_include_dirs:
  - .

sources:
  - csr_pkg.sv
  - csr_decode.sv
  - csr_regs.sv
  - csr_unit.sv
  - target: test
    files:
      - tb_csr_unit.sv

//--- build.f
+incdir+.
csr_pkg.sv
csr_decode.sv
csr_regs.sv
csr_unit.sv
tb_csr_unit.sv

//--- csr_decode.sv
// First CSR pipeline stage: decodes a Zicsr request into op, operand and write enable
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_decode import csr_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Request from the core
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  logic [2:0]            req_funct3_i,
    input  logic [11:0]           req_addr_i,
    input  logic [4:0]            req_rs1_idx_i,    // rs1 index or zimm
    input  logic [`CSR_XLEN-1:0]  req_rs1_data_i,

    // Decoded request to the register stage
    output logic                  dec_valid_o,
    input  logic                  dec_ready_i,
    output logic [11:0]           dec_addr_o,
    output logic [1:0]            dec_op_o,
    output logic [`CSR_XLEN-1:0]  dec_operand_o,
    output logic                  dec_we_o,
    output logic                  dec_illegal_o
);
    logic                 is_imm;
    logic [1:0]           op;
    logic [`CSR_XLEN-1:0] operand;
    logic                 we;
    logic                 illegal;
    logic                 load;

    logic                 valid_q;
    logic [11:0]          addr_q;
    logic [1:0]           op_q;
    logic [`CSR_XLEN-1:0] operand_q;
    logic                 we_q;
    logic                 illegal_q;

    assign is_imm = req_funct3_i[2];
    assign op     = req_funct3_i[1:0];

    // Immediate forms take the zero-extended zimm
    assign operand = is_imm ? {{(`CSR_XLEN-5){1'b0}}, req_rs1_idx_i} : req_rs1_data_i;

    // Set and clear with x0 / zero imm are pure reads
    always_comb begin
        if (op == F3_CSRRW[1:0]) begin
            we = 1'b1;
        end else begin
            we = (req_rs1_idx_i != 5'd0);
        end
    end

    // funct3 0 and 4 are not CSR ops; top address bits 11 mark read-only space
    assign illegal = (op == 2'b00) || (we && (req_addr_i[11:10] == 2'b11));

    // Stage empty or drained this cycle
    assign req_ready_o = !valid_q || dec_ready_i;
    assign load        = req_valid_i && req_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (req_ready_o) begin
            valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            addr_q    <= req_addr_i;
            op_q      <= op;
            operand_q <= operand;
            we_q      <= we;
            illegal_q <= illegal;
        end
    end

    assign dec_valid_o   = valid_q;
    assign dec_addr_o    = addr_q;
    assign dec_op_o      = op_q;
    assign dec_operand_o = operand_q;
    assign dec_we_o      = we_q;
    assign dec_illegal_o = illegal_q;

endmodule

//--- csr_defines.svh
// Width and machine ID constants for the CSR unit, included by the package, RTL and testbench
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// Register and data width of the whole unit
`define CSR_XLEN 32

// Machine information registers, read-only

// Zero marks a non-commercial implementation
`define CSR_MVENDORID 32'h0000_0000

// Open-source architecture ID
`define CSR_MARCHID 32'h0000_002a

// Implementation version 1.0
`define CSR_MIMPID 32'h0001_0000

`endif

//--- csr_pkg.sv
// Shared CSR addresses, funct3 codes, cause codes, masks and the mcause type; import with csr_pkg::*
`include "csr_defines.svh"

package csr_pkg;

    // Machine CSR addresses
    localparam logic [11:0] CSR_ADR_MSTATUS   = 12'h300;
    localparam logic [11:0] CSR_ADR_MISA      = 12'h301;
    localparam logic [11:0] CSR_ADR_MIE       = 12'h304;
    localparam logic [11:0] CSR_ADR_MTVEC     = 12'h305;
    localparam logic [11:0] CSR_ADR_MSCRATCH  = 12'h340;
    localparam logic [11:0] CSR_ADR_MEPC      = 12'h341;
    localparam logic [11:0] CSR_ADR_MCAUSE    = 12'h342;
    localparam logic [11:0] CSR_ADR_MTVAL     = 12'h343;
    localparam logic [11:0] CSR_ADR_MCYCLE    = 12'hB00;
    localparam logic [11:0] CSR_ADR_MVENDORID = 12'hF11;
    localparam logic [11:0] CSR_ADR_MARCHID   = 12'hF12;
    localparam logic [11:0] CSR_ADR_MIMPID    = 12'hF13;
    localparam logic [11:0] CSR_ADR_MHARTID   = 12'hF14;

    // Zicsr funct3, bit 2 selects the immediate form
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    // Exception codes that carry a faulting address in mtval
    localparam logic [`CSR_XLEN-2:0] EXC_LOAD_MISALIGNED  = 'd4;
    localparam logic [`CSR_XLEN-2:0] EXC_LOAD_FAULT       = 'd5;
    localparam logic [`CSR_XLEN-2:0] EXC_STORE_MISALIGNED = 'd6;
    localparam logic [`CSR_XLEN-2:0] EXC_STORE_FAULT      = 'd7;

    // mstatus fields
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam logic [`CSR_XLEN-1:0] MSTATUS_MASK  = 'h0000_0088;
    localparam logic [`CSR_XLEN-1:0] MSTATUS_MPP_M = 'h0000_1800;  // MPP hardwired to machine

    // MSIE, MTIE and MEIE
    localparam logic [`CSR_XLEN-1:0] MIE_MASK = 'h0000_0888;

    // Direct mode only, low two bits read as zero
    localparam logic [`CSR_XLEN-1:0] MTVEC_MASK = {{(`CSR_XLEN-2){1'b1}}, 2'b00};
    localparam logic [`CSR_XLEN-1:0] MEPC_MASK  = {{(`CSR_XLEN-2){1'b1}}, 2'b00};

    // MXL = 1 (32 bit), extension I
    localparam logic [`CSR_XLEN-1:0] MISA_VALUE = {2'b01, {(`CSR_XLEN-28){1'b0}}, 26'h000_0100};

    // mcause seen as an interrupt
    typedef struct packed {
        logic                  intr;       // Always 1 in this view
        logic [`CSR_XLEN-2:0]  irq_code;   // 3 soft, 7 timer, 11 external
    } mcause_irq_t;

    // mcause seen as a synchronous exception
    typedef struct packed {
        logic                  intr;       // Always 0 in this view
        logic [`CSR_XLEN-2:0]  exc_code;
    } mcause_exc_t;

    // Top bit decides which view applies
    typedef union packed {
        mcause_irq_t irq;
        mcause_exc_t exc;
    } mcause_t;

endpackage

//--- csr_regs.sv
// Second CSR pipeline stage: machine CSR file with read-modify-write, trap and mret updates
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_regs import csr_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_i,

    // Decoded request
    input  logic                  dec_valid_i,
    output logic                  dec_ready_o,
    input  logic [11:0]           dec_addr_i,
    input  logic [1:0]            dec_op_i,
    input  logic [`CSR_XLEN-1:0]  dec_operand_i,
    input  logic                  dec_we_i,
    input  logic                  dec_illegal_i,

    // Response to the core
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output logic [`CSR_XLEN-1:0]  rsp_rdata_o,      // Value before the write
    output logic                  rsp_illegal_o,

    // Trap entry and return strobes
    input  logic                  trap_i,
    input  logic                  trap_intr_i,
    input  logic [`CSR_XLEN-2:0]  trap_code_i,
    input  logic [`CSR_XLEN-1:0]  trap_pc_i,
    input  logic [`CSR_XLEN-1:0]  trap_val_i,
    input  logic                  mret_i,
    input  logic [`CSR_XLEN-1:0]  hartid_i,

    // Side-band state to the core
    output logic [`CSR_XLEN-1:0]  trap_vec_o,
    output logic [`CSR_XLEN-1:0]  epc_o,
    output logic                  irq_ena_o,
    output logic [`CSR_XLEN-1:0]  irq_ena_vec_o
);
    // Machine CSRs
    logic [`CSR_XLEN-1:0] mstatus_q;   // Holds MIE and MPIE only
    logic [`CSR_XLEN-1:0] mie_q;
    logic [`CSR_XLEN-1:0] mtvec_q;
    logic [`CSR_XLEN-1:0] mscratch_q;
    logic [`CSR_XLEN-1:0] mepc_q;
    mcause_t              mcause_q;
    logic [`CSR_XLEN-1:0] mtval_q;
    logic [`CSR_XLEN-1:0] mcycle_q;

    logic                 accept;
    logic                 hit;
    logic                 illegal;
    logic                 wr_en;
    logic [`CSR_XLEN-1:0] old_val;
    logic [`CSR_XLEN-1:0] new_val;
    mcause_t              trap_cause;
    logic                 trap_has_val;

    logic                 rsp_valid_q;
    logic [`CSR_XLEN-1:0] rsp_rdata_q;
    logic                 rsp_illegal_q;

    // Trap and mret own the register file for their cycle
    assign dec_ready_o = (!rsp_valid_q || rsp_ready_i) && !trap_i && !mret_i;
    assign accept      = dec_valid_i && dec_ready_o;

    // Read side
    always_comb begin
        hit     = 1'b1;
        old_val = '0;
        case (dec_addr_i)
            CSR_ADR_MSTATUS:   old_val = mstatus_q | MSTATUS_MPP_M;
            CSR_ADR_MISA:      old_val = MISA_VALUE;
            CSR_ADR_MIE:       old_val = mie_q;
            CSR_ADR_MTVEC:     old_val = mtvec_q;
            CSR_ADR_MSCRATCH:  old_val = mscratch_q;
            CSR_ADR_MEPC:      old_val = mepc_q;
            CSR_ADR_MCAUSE:    old_val = mcause_q;
            CSR_ADR_MTVAL:     old_val = mtval_q;
            CSR_ADR_MCYCLE:    old_val = mcycle_q;
            CSR_ADR_MVENDORID: old_val = `CSR_MVENDORID;
            CSR_ADR_MARCHID:   old_val = `CSR_MARCHID;
            CSR_ADR_MIMPID:    old_val = `CSR_MIMPID;
            CSR_ADR_MHARTID:   old_val = hartid_i;
            default:           hit = 1'b0;   // Unimplemented
        endcase
    end

    assign illegal = dec_illegal_i || !hit;

    // Modify
    always_comb begin
        case (dec_op_i)
            F3_CSRRS[1:0]: new_val = old_val | dec_operand_i;
            F3_CSRRC[1:0]: new_val = old_val & ~dec_operand_i;
            default:       new_val = dec_operand_i;
        endcase
    end

    assign wr_en = accept && dec_we_i && !illegal;

    // Cause word built through the view the core asked for
    always_comb begin
        trap_cause = '0;
        if (trap_intr_i) begin
            trap_cause.irq.intr     = 1'b1;
            trap_cause.irq.irq_code = trap_code_i;
        end else begin
            trap_cause.exc.intr     = 1'b0;
            trap_cause.exc.exc_code = trap_code_i;
        end
    end

    // Only misaligned and faulting loads/stores report an address
    assign trap_has_val = !trap_intr_i &&
                          (trap_code_i inside {EXC_LOAD_MISALIGNED, EXC_LOAD_FAULT,
                                               EXC_STORE_MISALIGNED, EXC_STORE_FAULT});

    // mstatus, trap beats mret
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus_q <= '0;
        end else if (trap_i) begin
            mstatus_q[MSTATUS_MPIE_BIT] <= mstatus_q[MSTATUS_MIE_BIT];
            mstatus_q[MSTATUS_MIE_BIT]  <= 1'b0;
        end else if (mret_i) begin
            mstatus_q[MSTATUS_MIE_BIT]  <= mstatus_q[MSTATUS_MPIE_BIT];
            mstatus_q[MSTATUS_MPIE_BIT] <= 1'b1;
        end else if (wr_en && dec_addr_i == CSR_ADR_MSTATUS) begin
            mstatus_q <= new_val & MSTATUS_MASK;
        end
    end

    // Trap handling registers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end else if (trap_i) begin
            mepc_q   <= trap_pc_i & MEPC_MASK;
            mcause_q <= trap_cause;
            mtval_q  <= trap_has_val ? trap_val_i : '0;
        end else if (wr_en) begin
            case (dec_addr_i)
                CSR_ADR_MEPC:   mepc_q   <= new_val & MEPC_MASK;
                CSR_ADR_MCAUSE: mcause_q <= new_val;
                CSR_ADR_MTVAL:  mtval_q  <= new_val;
                default: ;
            endcase
        end
    end

    // Plain writable registers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mie_q      <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
        end else if (wr_en) begin
            case (dec_addr_i)
                CSR_ADR_MIE:      mie_q      <= new_val & MIE_MASK;
                CSR_ADR_MTVEC:    mtvec_q    <= new_val & MTVEC_MASK;
                CSR_ADR_MSCRATCH: mscratch_q <= new_val;
                default: ;
            endcase
        end
    end

    // Free-running, writes have no effect
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mcycle_q <= '0;
        end else begin
            mcycle_q <= mcycle_q + 1'b1;
        end
    end

    // Response slot
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_q <= 1'b0;
        end else if (accept) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            rsp_rdata_q   <= illegal ? '0 : old_val;
            rsp_illegal_q <= illegal;
        end
    end

    assign rsp_valid_o   = rsp_valid_q;
    assign rsp_rdata_o   = rsp_rdata_q;
    assign rsp_illegal_o = rsp_illegal_q;

    assign trap_vec_o    = mtvec_q;
    assign epc_o         = mepc_q;
    assign irq_ena_o     = mstatus_q[MSTATUS_MIE_BIT];
    assign irq_ena_vec_o = mie_q;

endmodule

//--- csr_unit.sv
// Top of the machine CSR unit: decode stage followed by the register stage
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_unit (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  logic [2:0]            req_funct3_i,
    input  logic [11:0]           req_addr_i,
    input  logic [4:0]            req_rs1_idx_i,
    input  logic [`CSR_XLEN-1:0]  req_rs1_data_i,
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output logic [`CSR_XLEN-1:0]  rsp_rdata_o,
    output logic                  rsp_illegal_o,
    input  logic                  trap_i,
    input  logic                  trap_intr_i,
    input  logic [`CSR_XLEN-2:0]  trap_code_i,
    input  logic [`CSR_XLEN-1:0]  trap_pc_i,
    input  logic [`CSR_XLEN-1:0]  trap_val_i,
    input  logic                  mret_i,
    input  logic [`CSR_XLEN-1:0]  hartid_i,
    output logic [`CSR_XLEN-1:0]  trap_vec_o,
    output logic [`CSR_XLEN-1:0]  epc_o,
    output logic                  irq_ena_o,
    output logic [`CSR_XLEN-1:0]  irq_ena_vec_o
);
    // Decode to register stage
    logic                 dec_valid;
    logic                 dec_ready;
    logic [11:0]          dec_addr;
    logic [1:0]           dec_op;
    logic [`CSR_XLEN-1:0] dec_operand;
    logic                 dec_we;
    logic                 dec_illegal;

    csr_decode u_decode (
        .clk_i, .rst_i,
        .req_valid_i, .req_ready_o, .req_funct3_i, .req_addr_i, .req_rs1_idx_i, .req_rs1_data_i,
        .dec_valid_o (dec_valid), .dec_ready_i (dec_ready), .dec_addr_o (dec_addr),
        .dec_op_o (dec_op), .dec_operand_o (dec_operand), .dec_we_o (dec_we),
        .dec_illegal_o (dec_illegal)
    );

    csr_regs u_regs (
        .clk_i, .rst_i,
        .dec_valid_i (dec_valid), .dec_ready_o (dec_ready), .dec_addr_i (dec_addr),
        .dec_op_i (dec_op), .dec_operand_i (dec_operand), .dec_we_i (dec_we),
        .dec_illegal_i (dec_illegal),
        .rsp_valid_o, .rsp_ready_i, .rsp_rdata_o, .rsp_illegal_o,
        .trap_i, .trap_intr_i, .trap_code_i, .trap_pc_i, .trap_val_i, .mret_i, .hartid_i,
        .trap_vec_o, .epc_o, .irq_ena_o, .irq_ena_vec_o
    );

endmodule

//--- tb_csr_unit.sv
// Self-checking testbench that runs csr_unit against a reference model as the simulation top
`timescale 1ns/1ps
`include "csr_defines.svh"

module tb_csr_unit import csr_pkg::*; ();
    localparam int TIMEOUT_CYCLES = 6000;   // About 10 cycles per request for ~500 random and directed
    localparam int RANDOM_REQS    = 500;

    typedef struct packed {
        logic                 illegal;
        logic                 skip;     // Mcycle read checked for increase only
        logic [`CSR_XLEN-1:0] data;
    } exp_t;

    logic clk_i = 1'b0;
    logic rst_i;
    logic req_valid_i, req_ready_o, rsp_valid_o, rsp_ready_i, rsp_illegal_o;
    logic [2:0] req_funct3_i;
    logic [11:0] req_addr_i;
    logic [4:0] req_rs1_idx_i;
    logic [`CSR_XLEN-1:0] req_rs1_data_i, rsp_rdata_o, trap_pc_i, trap_val_i, hartid_i;
    logic trap_i, trap_intr_i, mret_i, irq_ena_o;
    logic [`CSR_XLEN-2:0] trap_code_i;
    logic [`CSR_XLEN-1:0] trap_vec_o, epc_o, irq_ena_vec_o;

    // Reference register file
    logic [`CSR_XLEN-1:0] m_mstatus = '0, m_mie = '0, m_mtvec = '0, m_mscratch = '0;
    logic [`CSR_XLEN-1:0] m_mepc = '0, m_mcause = '0, m_mtval = '0;

    exp_t exp_q[$];
    int unsigned cycle_cnt = 0;
    logic [`CSR_XLEN-1:0] last_rdata = '0, last_cycle = '0;
    logic [11:0] addr_list [0:14];
    logic rand_ready = 1'b0;

    csr_unit u_dut (
        .clk_i, .rst_i, .req_valid_i, .req_ready_o, .req_funct3_i, .req_addr_i,
        .req_rs1_idx_i, .req_rs1_data_i, .rsp_valid_o, .rsp_ready_i, .rsp_rdata_o,
        .rsp_illegal_o, .trap_i, .trap_intr_i, .trap_code_i, .trap_pc_i, .trap_val_i,
        .mret_i, .hartid_i, .trap_vec_o, .epc_o, .irq_ena_o, .irq_ena_vec_o
    );

    always #5 clk_i = ~clk_i;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    // Predict the response of an accepted request and update the model
    task automatic apply_req(input logic [2:0] f3, input logic [11:0] addr,
                             input logic [4:0] idx, input logic [`CSR_XLEN-1:0] data);
        logic [`CSR_XLEN-1:0] opnd, old_v, new_v;
        logic we, hit, bad;
        exp_t e;
        opnd = f3[2] ? {{(`CSR_XLEN-5){1'b0}}, idx} : data;
        we   = (f3[1:0] == 2'b01) || (idx != 5'd0);
        hit  = 1'b1;
        case (addr)
            CSR_ADR_MSTATUS:   old_v = m_mstatus | MSTATUS_MPP_M;
            CSR_ADR_MISA:      old_v = MISA_VALUE;
            CSR_ADR_MIE:       old_v = m_mie;
            CSR_ADR_MTVEC:     old_v = m_mtvec;
            CSR_ADR_MSCRATCH:  old_v = m_mscratch;
            CSR_ADR_MEPC:      old_v = m_mepc;
            CSR_ADR_MCAUSE:    old_v = m_mcause;
            CSR_ADR_MTVAL:     old_v = m_mtval;
            CSR_ADR_MCYCLE:    old_v = '0;
            CSR_ADR_MVENDORID: old_v = `CSR_MVENDORID;
            CSR_ADR_MARCHID:   old_v = `CSR_MARCHID;
            CSR_ADR_MIMPID:    old_v = `CSR_MIMPID;
            CSR_ADR_MHARTID:   old_v = hartid_i;
            default: begin
                hit   = 1'b0;
                old_v = '0;
            end
        endcase
        bad = (f3[1:0] == 2'b00) || !hit || (we && addr[11:10] == 2'b11);
        case (f3[1:0])
            2'b10:   new_v = old_v | opnd;
            2'b11:   new_v = old_v & ~opnd;
            default: new_v = opnd;
        endcase
        if (we && !bad) begin
            case (addr)                         // misa and mcycle ignore writes
                CSR_ADR_MSTATUS:  m_mstatus  = new_v & MSTATUS_MASK;
                CSR_ADR_MIE:      m_mie      = new_v & MIE_MASK;
                CSR_ADR_MTVEC:    m_mtvec    = new_v & MTVEC_MASK;
                CSR_ADR_MSCRATCH: m_mscratch = new_v;
                CSR_ADR_MEPC:     m_mepc     = new_v & MEPC_MASK;
                CSR_ADR_MCAUSE:   m_mcause   = new_v;
                CSR_ADR_MTVAL:    m_mtval    = new_v;
                default: ;
            endcase
        end
        e.illegal = bad;
        e.skip    = !bad && (addr == CSR_ADR_MCYCLE);
        e.data    = bad ? '0 : old_v;
        exp_q.push_back(e);
    endtask

    task automatic apply_trap();
        m_mepc   = trap_pc_i & MEPC_MASK;
        m_mcause = {trap_intr_i, trap_code_i};
        m_mtval  = (!trap_intr_i && trap_code_i >= EXC_LOAD_MISALIGNED &&
                    trap_code_i <= EXC_STORE_FAULT) ? trap_val_i : '0;
        m_mstatus[MSTATUS_MPIE_BIT] = m_mstatus[MSTATUS_MIE_BIT];
        m_mstatus[MSTATUS_MIE_BIT]  = 1'b0;
    endtask

    task automatic check_rsp();
        exp_t e;
        assert (exp_q.size() != 0)
            else abort_run("Response handshake arrived with no request outstanding");
        e = exp_q.pop_front();
        last_rdata = rsp_rdata_o;
        assert (rsp_illegal_o == e.illegal)
            else abort_run($sformatf("FAILED rsp_illegal_o got 0x%h expected 0x%h",
                                     rsp_illegal_o, e.illegal));
        if (e.skip) begin
            assert (rsp_rdata_o > last_cycle)
                else abort_run($sformatf("FAILED rsp_rdata_o mcycle got 0x%h after 0x%h",
                                         rsp_rdata_o, last_cycle));
            last_cycle = rsp_rdata_o;
        end else begin
            assert (rsp_rdata_o == e.data)
                else abort_run($sformatf("FAILED rsp_rdata_o got 0x%h expected 0x%h",
                                         rsp_rdata_o, e.data));
        end
    endtask

    // Only meaningful with no write in flight
    task automatic check_sideband();
        assert (trap_vec_o == m_mtvec)
            else abort_run($sformatf("FAILED trap_vec_o got 0x%h expected 0x%h",
                                     trap_vec_o, m_mtvec));
        assert (epc_o == m_mepc)
            else abort_run($sformatf("FAILED epc_o got 0x%h expected 0x%h", epc_o, m_mepc));
        assert (irq_ena_o == m_mstatus[MSTATUS_MIE_BIT])
            else abort_run($sformatf("FAILED irq_ena_o got 0x%h expected 0x%h",
                                     irq_ena_o, m_mstatus[MSTATUS_MIE_BIT]));
        assert (irq_ena_vec_o == m_mie)
            else abort_run($sformatf("FAILED irq_ena_vec_o got 0x%h expected 0x%h",
                                     irq_ena_vec_o, m_mie));
    endtask

    // Monitor sees inputs settled since the falling edge
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            abort_run("Timeout: the run did not finish within the cycle limit");
        if (!rst_i) begin
            if (rsp_valid_o && rsp_ready_i) check_rsp();
            if (exp_q.size() == 0) check_sideband();
            if (trap_i) begin
                apply_trap();
            end else if (mret_i) begin
                m_mstatus[MSTATUS_MIE_BIT]  = m_mstatus[MSTATUS_MPIE_BIT];
                m_mstatus[MSTATUS_MPIE_BIT] = 1'b1;
            end
            if (req_valid_i && req_ready_o)
                apply_req(req_funct3_i, req_addr_i, req_rs1_idx_i, req_rs1_data_i);
        end
    end

    always @(negedge clk_i) begin
        if (rand_ready) rsp_ready_i = ($urandom % 4) != 0;   // 25 % back-pressure
    end

    // Called and returns on a falling edge
    task automatic send_req(input logic [2:0] f3, input logic [11:0] addr,
                            input logic [4:0] idx, input logic [`CSR_XLEN-1:0] data);
        req_valid_i    = 1'b1;
        req_funct3_i   = f3;
        req_addr_i     = addr;
        req_rs1_idx_i  = idx;
        req_rs1_data_i = data;
        do @(posedge clk_i); while (!req_ready_o);
        @(negedge clk_i);
        req_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(negedge clk_i);
        @(negedge clk_i);                      // Lets the side-band check run once idle
    endtask

    task automatic pulse_strobe(input logic is_trap, input logic intr,
                                input logic [`CSR_XLEN-2:0] code);
        trap_intr_i = intr;
        trap_code_i = code;
        trap_pc_i   = $urandom;
        trap_val_i  = $urandom;
        trap_i      = is_trap;
        mret_i      = !is_trap;
        @(negedge clk_i);
        trap_i = 1'b0;
        mret_i = 1'b0;
    endtask

    task automatic check_cause(input logic intr, input logic [`CSR_XLEN-2:0] code);
        mcause_t seen;
        seen = last_rdata;
        assert (seen.irq.intr == intr && (intr ? seen.irq.irq_code : seen.exc.exc_code) == code)
            else abort_run($sformatf("FAILED mcause got 0x%h expected intr 0x%h code 0x%h",
                                     seen, intr, code));
    endtask

    initial begin
        logic intr;
        logic [`CSR_XLEN-2:0] code;
        logic [4:0] idx;
        logic [2:0] forms [0:5];
        void'($urandom(32'h90ca_026f));
        forms     = '{F3_CSRRW, F3_CSRRS, F3_CSRRC, F3_CSRRWI, F3_CSRRSI, F3_CSRRCI};
        addr_list = '{CSR_ADR_MSTATUS, CSR_ADR_MISA, CSR_ADR_MIE, CSR_ADR_MTVEC,
                      CSR_ADR_MSCRATCH, CSR_ADR_MEPC, CSR_ADR_MCAUSE, CSR_ADR_MTVAL,
                      CSR_ADR_MCYCLE, CSR_ADR_MVENDORID, CSR_ADR_MARCHID, CSR_ADR_MIMPID,
                      CSR_ADR_MHARTID, 12'h7c0, 12'h3a0};   // last two unimplemented
        rst_i = 1'b1;
        {req_valid_i, trap_i, trap_intr_i, mret_i} = '0;
        {req_funct3_i, req_addr_i, req_rs1_idx_i, req_rs1_data_i} = '0;
        {trap_code_i, trap_pc_i, trap_val_i} = '0;
        rsp_ready_i = 1'b1;
        hartid_i    = $urandom;
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // Reset values of every implemented CSR
        for (int i = 0; i < 13; i++) send_req(F3_CSRRS, addr_list[i], 5'd0, $urandom);
        drain();
        // All six forms on mscratch with a zero index first
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 6; k++) begin
                idx = (k == 0) ? 5'd0 : 5'($urandom);
                send_req(forms[i], CSR_ADR_MSCRATCH, idx, $urandom);
            end
        end
        // Masks read back after an all-ones write
        for (int i = 0; i < 4; i++) begin
            send_req(F3_CSRRW, addr_list[(i == 0) ? 0 : i + 1 + (i == 3)], 5'd1, '1);
            send_req(F3_CSRRS, addr_list[(i == 0) ? 0 : i + 1 + (i == 3)], 5'd0, '0);
        end
        drain();
        // Illegal requests followed by an mscratch read
        send_req(F3_CSRRS, 12'h7c0, 5'd0, '0);
        send_req(F3_CSRRW, 12'h3a0, 5'd3, $urandom);
        send_req(3'b000, CSR_ADR_MSCRATCH, 5'd7, $urandom);
        send_req(3'b100, CSR_ADR_MSCRATCH, 5'd7, $urandom);
        for (int i = 9; i < 13; i++) send_req(F3_CSRRW, addr_list[i], 5'd2, $urandom);
        send_req(F3_CSRRSI, CSR_ADR_MHARTID, 5'd4, '0);
        send_req(F3_CSRRS, CSR_ADR_MHARTID, 5'd0, $urandom);
        send_req(F3_CSRRS, CSR_ADR_MSCRATCH, 5'd0, '0);
        drain();
        // Trap entry and mret
        for (int i = 0; i < 8; i++) begin
            send_req(F3_CSRRW, CSR_ADR_MSTATUS, 5'd1, $urandom);
            drain();
            intr = 1'($urandom);
            code = (`CSR_XLEN-1)'($urandom % 12);
            pulse_strobe(1'b1, intr, code);
            send_req(F3_CSRRS, CSR_ADR_MEPC, 5'd0, '0);
            send_req(F3_CSRRS, CSR_ADR_MTVAL, 5'd0, '0);
            send_req(F3_CSRRS, CSR_ADR_MSTATUS, 5'd0, '0);
            send_req(F3_CSRRS, CSR_ADR_MCAUSE, 5'd0, '0);
            drain();
            check_cause(intr, code);
            pulse_strobe(1'b0, 1'b0, '0);
            send_req(F3_CSRRS, CSR_ADR_MSTATUS, 5'd0, '0);
            drain();
        end
        // Random stream with back-pressure and strobes only while idle
        rand_ready = 1'b1;
        for (int i = 0; i < RANDOM_REQS; i++) begin
            if ($urandom % 16 < 2) begin
                drain();
                pulse_strobe(1'($urandom % 2), 1'($urandom % 2),
                             (`CSR_XLEN-1)'($urandom % 12));
            end
            idx = ($urandom % 4 == 0) ? 5'd0 : 5'($urandom);
            send_req(3'($urandom % 8), addr_list[$urandom % 15], idx, $urandom);
        end
        rand_ready  = 1'b0;
        rsp_ready_i = 1'b1;
        drain();

        $display("Verification passed");
        $finish;
    end

endmodule
